/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;
    localparam int I_IMM_W   = 12;
    localparam int U_IMM_W   = 20;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;
    typedef logic [FUNCT7_W-1:0]  funct7_t;

    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    localparam funct3_t F3_ADD  = 3'b000; // also sub
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // srl and sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // b-offset bits 12:1 are {b_msb, i_imm[11:1]}
    typedef struct packed {
        logic [XLEN-I_IMM_W-2:0] upper;
        logic                    b_msb;
        logic [I_IMM_W-1:0]      i_imm;
    } imm_ib_t;

    typedef struct packed {
        logic [U_IMM_W-1:0]      u_imm;
        logic [XLEN-U_IMM_W-1:0] low;
    } imm_u_t;

    typedef union packed {
        imm_ib_t ib;
        imm_u_t  u;
    } imm_word_u;

endpackage

/* verilog/exec_pkg.sv */
package exec_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASS_B, // lui
        LINK    // pc + 4
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE,   // not a control transfer
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU,
        ALWAYS  // jal, jalr
    } br_cond_e;

    typedef enum logic {
        PC,
        RS1
    } jmp_base_e;

endpackage

/* verilog/exec_decode.sv */
`timescale 1ns/1ns

module exec_decode (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  valid,
    input  rv_isa_pkg::xlen_t     pc,
    input  rv_isa_pkg::opcode_t   opcode,
    input  rv_isa_pkg::reg_idx_t  rd,
    input  rv_isa_pkg::reg_idx_t  rs1,
    input  rv_isa_pkg::xlen_t     rs1_v,
    input  rv_isa_pkg::reg_idx_t  rs2,
    input  rv_isa_pkg::xlen_t     rs2_v,
    input  rv_isa_pkg::funct3_t   funct3,
    input  rv_isa_pkg::funct7_t   funct7,
    input  rv_isa_pkg::imm_word_u imm,
    input  rv_isa_pkg::reg_idx_t  fwd_a_idx,
    input  rv_isa_pkg::xlen_t     fwd_a_val,
    input  rv_isa_pkg::reg_idx_t  fwd_b_idx,
    input  rv_isa_pkg::xlen_t     fwd_b_val,
    input  rv_isa_pkg::reg_idx_t  fwd_c_idx,
    input  rv_isa_pkg::xlen_t     fwd_c_val,
    output logic                  op_valid,
    output exec_pkg::alu_op_e     alu_op,
    output exec_pkg::br_cond_e    br_cond,
    output exec_pkg::jmp_base_e   jmp_base,
    output rv_isa_pkg::xlen_t     op_a,
    output rv_isa_pkg::xlen_t     op_b,
    output rv_isa_pkg::xlen_t     pc_q,
    output rv_isa_pkg::xlen_t     imm_q,
    output rv_isa_pkg::reg_idx_t  link_rd
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic      valid_r;
    xlen_t     pc_r, rs1_v_r, rs2_v_r;
    opcode_t   opcode_r;
    reg_idx_t  rd_r, rs1_r, rs2_r;
    funct3_t   funct3_r;
    funct7_t   funct7_r;
    imm_word_u imm_r;
    xlen_t     rs1_f, rs2_f, imm_i, imm_u;
    logic      legal;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            valid_r <= 1'b0;
        else if (!stall)
            valid_r <= valid && !flush;
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            pc_r     <= pc;
            opcode_r <= opcode;
            rd_r     <= rd;
            rs1_r    <= rs1;
            rs1_v_r  <= rs1_v;
            rs2_r    <= rs2;
            rs2_v_r  <= rs2_v;
            funct3_r <= funct3;
            funct7_r <= funct7;
            imm_r    <= imm;
        end
    end

    // oldest-first priority a, b, c
    function automatic xlen_t forward(reg_idx_t src, xlen_t captured);
        if (src == fwd_a_idx)
            return fwd_a_val;
        else if (src == fwd_b_idx)
            return fwd_b_val;
        else if (src == fwd_c_idx)
            return fwd_c_val;
        return captured;
    endfunction

    assign rs1_f = forward(rs1_r, rs1_v_r);
    assign rs2_f = forward(rs2_r, rs2_v_r);

    assign imm_i = {{(XLEN-I_IMM_W){imm_r.ib.i_imm[I_IMM_W-1]}}, imm_r.ib.i_imm};
    assign imm_u = {imm_r.u.u_imm, {(XLEN-U_IMM_W){1'b0}}};

    always_comb begin
        legal    = 1'b1;
        alu_op   = ADD;
        br_cond  = NONE;
        jmp_base = PC;
        op_a     = rs1_f;
        op_b     = rs2_f;
        imm_q    = imm_i;
        case (opcode_r)
            OP_REG: begin
                case (funct3_r)
                    F3_ADD:  alu_op = (funct7_r == F7_ALT) ? SUB : ADD;
                    F3_SLL:  alu_op = SLL;
                    F3_SLT:  alu_op = SLT;
                    F3_SLTU: alu_op = SLTU;
                    F3_XOR:  alu_op = XOR;
                    F3_SR:   alu_op = (funct7_r == F7_ALT) ? SRA : SRL;
                    F3_OR:   alu_op = OR;
                    default: alu_op = AND;
                endcase
                legal = (funct7_r == F7_BASE) ||
                        (funct7_r == F7_ALT && (funct3_r == F3_ADD || funct3_r == F3_SR));
            end
            OP_IMM: begin
                op_b = imm_i;
                case (funct3_r)
                    F3_ADD:  alu_op = ADD;
                    F3_SLL:  alu_op = SLL;
                    F3_SLT:  alu_op = SLT;
                    F3_SLTU: alu_op = SLTU;
                    F3_XOR:  alu_op = XOR;
                    F3_SR:   alu_op = (funct7_r == F7_ALT) ? SRA : SRL;
                    F3_OR:   alu_op = OR;
                    default: alu_op = AND;
                endcase
                if (funct3_r == F3_SLL)
                    legal = (funct7_r == F7_BASE);
                else if (funct3_r == F3_SR)
                    legal = (funct7_r == F7_BASE) || (funct7_r == F7_ALT);
            end
            OP_LUI: begin
                alu_op = PASS_B;
                op_a   = '0;
                op_b   = imm_u;
            end
            OP_AUIPC: begin
                op_a = pc_r;
                op_b = imm_u;
            end
            OP_BRANCH: begin
                imm_q = {{(XLEN-I_IMM_W-1){imm_r.ib.b_msb}}, imm_r.ib.b_msb,
                         imm_r.ib.i_imm[I_IMM_W-1:1], 1'b0};
                case (funct3_r)
                    F3_BEQ:  br_cond = EQ;
                    F3_BNE:  br_cond = NE;
                    F3_BLT:  br_cond = LT;
                    F3_BGE:  br_cond = GE;
                    F3_BLTU: br_cond = LTU;
                    F3_BGEU: br_cond = GEU;
                    default: legal   = 1'b0;
                endcase
            end
            OP_JAL: begin
                alu_op  = LINK;
                br_cond = ALWAYS;
                imm_q   = {{11{imm_r[20]}}, imm_r[20:1], 1'b0}; // j-offset
            end
            OP_JALR: begin
                alu_op   = LINK;
                br_cond  = ALWAYS;
                jmp_base = RS1;
                legal    = (funct3_r == 3'b000);
            end
            default: legal = 1'b0;
        endcase
    end

    assign op_valid = valid_r && legal;
    assign pc_q     = pc_r;
    assign link_rd  = rd_r;

endmodule

/* verilog/exec_alu.sv */
`timescale 1ns/1ns

module exec_alu (
    input  logic                 op_valid,
    input  exec_pkg::alu_op_e    alu_op,
    input  exec_pkg::br_cond_e   br_cond,
    input  exec_pkg::jmp_base_e  jmp_base,
    input  rv_isa_pkg::xlen_t    op_a,
    input  rv_isa_pkg::xlen_t    op_b,
    input  rv_isa_pkg::xlen_t    pc_q,
    input  rv_isa_pkg::xlen_t    imm_q,
    input  rv_isa_pkg::reg_idx_t link_rd,
    output logic                 ex_valid,
    output logic                 wr_en,
    output rv_isa_pkg::reg_idx_t wr_idx,
    output rv_isa_pkg::xlen_t    wr_data,
    output logic                 jmp_do_c,
    output rv_isa_pkg::xlen_t    jmp_pc_c
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    xlen_t      result;
    xlen_t      target;
    logic [4:0] shamt;
    logic       taken;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            SLL:     result = op_a << shamt;
            SRL:     result = op_a >> shamt;
            SRA:     result = $signed(op_a) >>> shamt;
            SLT:     result = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    result = {31'b0, op_a < op_b};
            PASS_B:  result = op_b;
            LINK:    result = pc_q + 32'd4;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (br_cond)
            EQ:      taken = (op_a == op_b);
            NE:      taken = (op_a != op_b);
            LT:      taken = $signed(op_a) < $signed(op_b);
            GE:      taken = $signed(op_a) >= $signed(op_b);
            LTU:     taken = op_a < op_b;
            GEU:     taken = op_a >= op_b;
            ALWAYS:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jmp_base == RS1) begin
            target = op_a + imm_q;
            target[0] = 1'b0; // jalr clears lsb
        end else begin
            target = pc_q + imm_q;
        end
    end

    assign ex_valid = op_valid;
    assign wr_en    = op_valid && (br_cond == NONE || br_cond == ALWAYS);
    assign wr_idx   = link_rd;
    assign wr_data  = result;
    assign jmp_do_c = op_valid && taken;
    assign jmp_pc_c = target;

endmodule

/* verilog/exec_result.sv */
`timescale 1ns/1ns

module exec_result (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 ex_valid,
    input  logic                 wr_en,
    input  rv_isa_pkg::reg_idx_t wr_idx,
    input  rv_isa_pkg::xlen_t    wr_data,
    input  logic                 jmp_do_c,
    input  rv_isa_pkg::xlen_t    jmp_pc_c,
    output logic                 res_valid,
    output logic                 reg_w_en,
    output rv_isa_pkg::reg_idx_t reg_w_rd,
    output rv_isa_pkg::xlen_t    reg_w_data,
    output logic                 jmp_do,
    output rv_isa_pkg::xlen_t    jmp_pc
);
    import rv_isa_pkg::*;

    logic     slot_ok, w_en_d, jmp_d;
    reg_idx_t rd_d;
    xlen_t    data_d, jpc_d;

    // flushed or empty slots carry all-zero fields
    assign slot_ok = ex_valid && !flush;
    assign w_en_d  = slot_ok && wr_en;
    assign jmp_d   = slot_ok && jmp_do_c;
    assign rd_d    = w_en_d ? wr_idx : '0;
    assign data_d  = w_en_d ? wr_data : '0;
    assign jpc_d   = jmp_d ? jmp_pc_c : '0;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            res_valid  <= 1'b0;
            reg_w_en   <= 1'b0;
            reg_w_rd   <= '0;
            reg_w_data <= '0;
            jmp_do     <= 1'b0;
            jmp_pc     <= '0;
        end else if (!stall) begin
            res_valid  <= slot_ok;
            reg_w_en   <= w_en_d;
            reg_w_rd   <= rd_d;
            reg_w_data <= data_d;
            jmp_do     <= jmp_d;
            jmp_pc     <= jpc_d;
        end
    end

endmodule

/* verilog/exec_top.sv */
`timescale 1ns/1ns

module exec_top (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  valid,
    input  rv_isa_pkg::xlen_t     pc,
    input  rv_isa_pkg::opcode_t   opcode,
    input  rv_isa_pkg::reg_idx_t  rd,
    input  rv_isa_pkg::reg_idx_t  rs1,
    input  rv_isa_pkg::xlen_t     rs1_v,
    input  rv_isa_pkg::reg_idx_t  rs2,
    input  rv_isa_pkg::xlen_t     rs2_v,
    input  rv_isa_pkg::funct3_t   funct3,
    input  rv_isa_pkg::funct7_t   funct7,
    input  rv_isa_pkg::imm_word_u imm,
    input  rv_isa_pkg::reg_idx_t  fwd_a_idx,
    input  rv_isa_pkg::xlen_t     fwd_a_val,
    input  rv_isa_pkg::reg_idx_t  fwd_b_idx,
    input  rv_isa_pkg::xlen_t     fwd_b_val,
    input  rv_isa_pkg::reg_idx_t  fwd_c_idx,
    input  rv_isa_pkg::xlen_t     fwd_c_val,
    output logic                  res_valid,
    output logic                  reg_w_en,
    output rv_isa_pkg::reg_idx_t  reg_w_rd,
    output rv_isa_pkg::xlen_t     reg_w_data,
    output logic                  jmp_do,
    output rv_isa_pkg::xlen_t     jmp_pc
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    logic      op_valid, ex_valid, wr_en, jmp_do_c;
    alu_op_e   alu_op;
    br_cond_e  br_cond;
    jmp_base_e jmp_base;
    xlen_t     op_a, op_b, pc_q, imm_q, wr_data, jmp_pc_c;
    reg_idx_t  link_rd, wr_idx;

    exec_decode i_decode (
        .CLK(CLK), .arst_n(arst_n), .stall(stall), .flush(flush),
        .valid(valid), .pc(pc), .opcode(opcode), .rd(rd),
        .rs1(rs1), .rs1_v(rs1_v), .rs2(rs2), .rs2_v(rs2_v),
        .funct3(funct3), .funct7(funct7), .imm(imm),
        .fwd_a_idx(fwd_a_idx), .fwd_a_val(fwd_a_val),
        .fwd_b_idx(fwd_b_idx), .fwd_b_val(fwd_b_val),
        .fwd_c_idx(fwd_c_idx), .fwd_c_val(fwd_c_val),
        .op_valid(op_valid), .alu_op(alu_op), .br_cond(br_cond), .jmp_base(jmp_base),
        .op_a(op_a), .op_b(op_b), .pc_q(pc_q), .imm_q(imm_q), .link_rd(link_rd)
    );

    exec_alu i_alu (
        .op_valid(op_valid), .alu_op(alu_op), .br_cond(br_cond), .jmp_base(jmp_base),
        .op_a(op_a), .op_b(op_b), .pc_q(pc_q), .imm_q(imm_q), .link_rd(link_rd),
        .ex_valid(ex_valid), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .jmp_do_c(jmp_do_c), .jmp_pc_c(jmp_pc_c)
    );

    exec_result i_result (
        .CLK(CLK), .arst_n(arst_n), .stall(stall), .flush(flush),
        .ex_valid(ex_valid), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .jmp_do_c(jmp_do_c), .jmp_pc_c(jmp_pc_c),
        .res_valid(res_valid), .reg_w_en(reg_w_en), .reg_w_rd(reg_w_rd),
        .reg_w_data(reg_w_data), .jmp_do(jmp_do), .jmp_pc(jmp_pc)
    );

endmodule

/* tests/exec_clk.sv */
`timescale 1ns/1ns

module exec_clk (
    output logic CLK,
    output logic arst_n
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK; // 100 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge CLK);
        #10 arst_n = 1'b1;
    end

endmodule

/* tests/exec_chk.sv */
`timescale 1ns/1ns

module exec_chk (
    input logic                 CLK,
    input logic                 arst_n,
    input logic                 stall,
    input logic                 res_valid,
    input logic                 reg_w_en,
    input rv_isa_pkg::reg_idx_t reg_w_rd,
    input rv_isa_pkg::xlen_t    reg_w_data,
    input logic                 jmp_do,
    input rv_isa_pkg::xlen_t    jmp_pc
);

    jump_needs_valid: assert property (@(posedge CLK) disable iff (!arst_n)
        jmp_do |-> res_valid)
        else $error("jump output without a valid result");

    rd_zero_when_idle: assert property (@(posedge CLK) disable iff (!arst_n)
        !reg_w_en |-> reg_w_rd == '0)
        else $error("reg_w_rd nonzero while reg_w_en is low");

    hold_on_stall: assert property (@(posedge CLK) disable iff (!arst_n)
        stall |=> $stable({res_valid, reg_w_en, reg_w_rd, reg_w_data, jmp_do, jmp_pc}))
        else $error("result outputs changed across a stalled edge");

endmodule

bind exec_result exec_chk i_chk (.*);

/* tests/exec_tb.sv */
`timescale 1ns/1ns

module exec_tb;
    import rv_isa_pkg::*;

    localparam int STIM_CYCLES = 110;
    localparam int MAX_CYCLES  = 4 * STIM_CYCLES;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    rs1_v;
        xlen_t    rs2_v;
        funct3_t  funct3;
        funct7_t  funct7;
        xlen_t    imm;
    } instr_t;

    typedef struct packed {
        logic     legal;
        logic     w_en;
        reg_idx_t rd;
        xlen_t    data;
        logic     jdo;
        xlen_t    jpc;
    } res_t;

    logic      CLK, arst_n, stall, flush, valid;
    xlen_t     pc, rs1_v, rs2_v, fwd_a_val, fwd_b_val, fwd_c_val;
    opcode_t   opcode;
    reg_idx_t  rd, rs1, rs2, fwd_a_idx, fwd_b_idx, fwd_c_idx;
    funct3_t   funct3;
    funct7_t   funct7;
    imm_word_u imm;
    logic      res_valid, reg_w_en, jmp_do;
    reg_idx_t  reg_w_rd;
    xlen_t     reg_w_data, jmp_pc;

    int       seed = 2;
    int       errors = 0;
    int       compared = 0;
    int       cycles = 0;
    logic     loaded = 1'b0;
    logic     fwd_rand = 1'b1;
    reg_idx_t st_idx[3];
    xlen_t    st_val[3];
    instr_t   pend;
    instr_t   ins;
    res_t     exp_q[$];

    exec_clk i_clk (.CLK(CLK), .arst_n(arst_n));

    exec_top i_dut (.*);

    function automatic xlen_t rnd();
        return $random(seed);
    endfunction

    // first match among a, b, c wins
    function automatic xlen_t pick_operand(reg_idx_t src, xlen_t v);
        if (src == fwd_a_idx)
            return fwd_a_val;
        if (src == fwd_b_idx)
            return fwd_b_val;
        if (src == fwd_c_idx)
            return fwd_c_val;
        return v;
    endfunction

    function automatic xlen_t alu_ref(funct3_t f3, logic alt, xlen_t a, xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic res_t ref_exec(instr_t in);
        res_t  r;
        xlen_t a, b, i_imm, u_imm, b_off, j_off;
        logic  alt, taken;
        a     = pick_operand(in.rs1, in.rs1_v);
        b     = pick_operand(in.rs2, in.rs2_v);
        i_imm = {{20{in.imm[11]}}, in.imm[11:0]};
        u_imm = {in.imm[31:12], 12'h000};
        b_off = {{19{in.imm[12]}}, in.imm[12:1], 1'b0};
        j_off = {{11{in.imm[20]}}, in.imm[20:1], 1'b0};
        alt   = (in.funct7 == F7_ALT);
        r     = '0;
        r.legal = 1'b1;
        r.w_en  = 1'b1;
        r.rd    = in.rd;
        case (in.opcode)
            OP_REG: begin
                r.legal = (in.funct7 == F7_BASE) ||
                          (alt && (in.funct3 == 3'd0 || in.funct3 == 3'd5));
                r.data  = alu_ref(in.funct3, alt, a, b);
            end
            OP_IMM: begin
                if (in.funct3 == 3'd1)
                    r.legal = (in.funct7 == F7_BASE);
                else if (in.funct3 == 3'd5)
                    r.legal = (in.funct7 == F7_BASE) || alt;
                r.data = alu_ref(in.funct3, alt && in.funct3 == 3'd5, a, i_imm);
            end
            OP_LUI:   r.data = u_imm;
            OP_AUIPC: r.data = in.pc + u_imm;
            OP_BRANCH: begin
                r.w_en = 1'b0;
                r.rd   = '0;
                case (in.funct3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: begin
                        taken   = 1'b0;
                        r.legal = 1'b0;
                    end
                endcase
                r.jdo = taken;
                r.jpc = taken ? in.pc + b_off : '0;
            end
            OP_JAL: begin
                r.data = in.pc + 32'd4;
                r.jdo  = 1'b1;
                r.jpc  = in.pc + j_off;
            end
            OP_JALR: begin
                r.legal = (in.funct3 == 3'd0);
                r.data  = in.pc + 32'd4;
                r.jdo   = 1'b1;
                r.jpc   = (a + i_imm) & ~32'd1;
            end
            default: r.legal = 1'b0;
        endcase
        return r;
    endfunction

    function automatic instr_t rand_instr();
        instr_t  n;
        xlen_t   s;
        opcode_t ops[10];
        ops = '{OP_REG, OP_REG, OP_REG, OP_IMM, OP_IMM, OP_IMM, OP_LUI, OP_AUIPC,
                OP_BRANCH, 7'b0000011};
        s        = rnd();
        n.valid  = 1'b1;
        n.opcode = ops[s[31:4] % 10];
        n.funct3 = s[2:0];
        n.funct7 = s[3] ? F7_ALT : F7_BASE;
        n.rd     = reg_idx_t'(rnd());
        n.rs1    = reg_idx_t'(rnd() & 32'h3); // small range so forwarding hits
        n.rs2    = reg_idx_t'(rnd() & 32'h3);
        n.rs1_v  = rnd();
        n.rs2_v  = rnd();
        n.imm    = rnd();
        n.pc     = rnd() & ~32'd3;
        return n;
    endfunction

    task automatic check_field(input string name, input xlen_t exp_v, input xlen_t act_v);
        assert (act_v === exp_v) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic drive(input instr_t n);
        valid  = n.valid;
        pc     = n.pc;
        opcode = n.opcode;
        rd     = n.rd;
        rs1    = n.rs1;
        rs2    = n.rs2;
        rs1_v  = n.rs1_v;
        rs2_v  = n.rs2_v;
        funct3 = n.funct3;
        funct7 = n.funct7;
        imm    = n.imm;
    endtask

    // forwarding values set here belong to the instruction captured at this edge
    task automatic step(input instr_t nxt, input logic do_flush);
        res_t r;
        @(posedge CLK);
        #10;
        if (fwd_rand) begin
            fwd_a_idx = reg_idx_t'(rnd() & 32'h3);
            fwd_b_idx = reg_idx_t'(rnd() & 32'h3);
            fwd_c_idx = reg_idx_t'(rnd() & 32'h3);
            fwd_a_val = rnd();
            fwd_b_val = rnd();
            fwd_c_val = rnd();
        end else begin
            fwd_a_idx = st_idx[0];
            fwd_b_idx = st_idx[1];
            fwd_c_idx = st_idx[2];
            fwd_a_val = st_val[0];
            fwd_b_val = st_val[1];
            fwd_c_val = st_val[2];
        end
        if (pend.valid && !do_flush) begin
            r = ref_exec(pend);
            if (r.legal)
                exp_q.push_back(r);
        end
        drive(nxt);
        flush = do_flush;
        pend  = nxt;
        if (do_flush)
            pend.valid = 1'b0;
    endtask

    task automatic hold_stall(input int n);
        stall = 1'b1;
        repeat (n) @(posedge CLK);
        #10 stall = 1'b0;
    endtask

    always @(posedge CLK) begin
        res_t e;
        if (loaded && res_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected result at %0t with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                compared++;
                check_field("reg_w_en", 32'(e.w_en), 32'(reg_w_en));
                check_field("reg_w_rd", 32'(e.rd), 32'(reg_w_rd));
                check_field("reg_w_data", e.data, reg_w_data);
                check_field("jmp_do", 32'(e.jdo), 32'(jmp_do));
                check_field("jmp_pc", e.jpc, jmp_pc);
            end
        end
        loaded = arst_n && !stall; // outputs reloaded at this edge
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        instr_t idle;
        idle = '0;
        pend = '0;
        stall = 1'b0;
        flush = 1'b0;
        drive(idle);
        fwd_a_idx = '0;
        fwd_b_idx = '0;
        fwd_c_idx = '0;
        fwd_a_val = '0;
        fwd_b_val = '0;
        fwd_c_val = '0;
        st_idx = '{5'd31, 5'd31, 5'd31};
        st_val = '{32'd0, 32'd0, 32'd0};
        wait (arst_n);
        check_field("res_valid", 32'd0, 32'(res_valid));
        check_field("reg_w_en", 32'd0, 32'(reg_w_en));
        check_field("reg_w_rd", 32'd0, 32'(reg_w_rd));
        check_field("reg_w_data", 32'd0, reg_w_data);
        check_field("jmp_do", 32'd0, 32'(jmp_do));
        check_field("jmp_pc", 32'd0, jmp_pc);

        repeat (60) step(rand_instr(), 1'b0);

        fwd_rand = 1'b0; // fixed operands for branches and jumps
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 3; k++) begin
                ins        = rand_instr();
                ins.opcode = OP_BRANCH;
                ins.funct3 = f[2:0];
                ins.rs1    = 5'd1;
                ins.rs2    = 5'd2;
                ins.rs1_v  = (k == 0) ? 32'd5 : (k == 1) ? 32'hffff_fffd : 32'd2;
                ins.rs2_v  = (k == 0) ? 32'd5 : (k == 1) ? 32'd2 : 32'hffff_fff0;
                if (f != 2 && f != 3)
                    step(ins, 1'b0);
            end
        end
        ins        = rand_instr();
        ins.opcode = OP_JAL;
        step(ins, 1'b0);
        ins        = rand_instr();
        ins.opcode = OP_JALR;
        ins.funct3 = 3'd0;
        ins.rs1    = 5'd1;
        ins.rs1_v  = 32'h0000_1001; // odd base
        ins.imm[0] = 1'b0;
        step(ins, 1'b0);

        ins        = rand_instr();
        ins.opcode = OP_REG;
        ins.funct3 = 3'd0;
        ins.funct7 = F7_BASE;
        ins.rs1    = 5'd3;
        ins.rs2    = 5'd3;
        step(ins, 1'b0);
        st_idx = '{5'd3, 5'd3, 5'd3};
        st_val = '{32'h1111_0000, 32'h2222_0000, 32'h3333_0000};
        step(ins, 1'b0);
        st_idx = '{5'd31, 5'd3, 5'd3};
        step(idle, 1'b0);
        fwd_rand = 1'b1;

        step(rand_instr(), 1'b0);
        step(rand_instr(), 1'b0);
        hold_stall(3);
        step(rand_instr(), 1'b0);
        step(rand_instr(), 1'b1); // drops both instructions in flight
        step(rand_instr(), 1'b0);

        ins        = rand_instr();
        ins.opcode = OP_REG;
        ins.funct7 = 7'b0000001;
        step(ins, 1'b0);
        ins.opcode = 7'b1110011;
        step(ins, 1'b0);

        repeat (4) step(idle, 1'b0);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected results never appeared on the outputs", exp_q.size());
        end
        $display("%0d errors, %0d results compared", errors, compared);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* files.f */
verilog/rv_isa_pkg.sv
verilog/exec_pkg.sv
verilog/exec_decode.sv
verilog/exec_alu.sv
verilog/exec_result.sv
verilog/exec_top.sv
tests/exec_clk.sv
tests/exec_chk.sv
tests/exec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module exec_tb -f files.f -o exec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/exec_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
